/* list.f */
+incdir+sim
hw/core_pkg.sv
hw/bridge_settings.sv
hw/dataslot_tracker.sv
hw/datatable_sequencer.sv
hw/key_sync.sv
hw/video_conditioner.sv
hw/core_top.sv
sim/tb_core_top.sv

/* Makefile */
VERILATOR  := verilator
FLAGS      := --binary --timing --timescale 1ns/1ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
TOP        := tb_core_top
RTL_TOP    := core_top
FILELIST   := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides the result, the simulator exit code alone does not
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_checks.svh */
// Compare tasks and the data-table wait for the core_top testbench.
// Included inside tb_core_top after the core_pkg import; uses stop_on_error,
// clk_74a, datatable_wren and WAIT_LIMIT from that module.

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  task automatic report_mismatch(input string name, input string expected, input string actual);
    $display("CHECK FAILED at %0t: %s expected %s, actual %s", $time, name, expected, actual);
    stop_on_error();
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected)
      report_mismatch(name, $sformatf("%0b", expected), $sformatf("%0b", actual));
  endtask

  task automatic check_data(input string name, input bridge_data_t actual,
                            input bridge_data_t expected);
    if (actual !== expected)
      report_mismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
  endtask

  task automatic check_addr(input string name, input datatable_addr_t actual,
                            input datatable_addr_t expected);
    if (actual !== expected)
      report_mismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
  endtask

  task automatic check_key(input string name, input key_word_t actual, input key_word_t expected);
    if (actual !== expected)
      report_mismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
  endtask

  task automatic check_rgb(input string name, input rgb_t actual, input rgb_t expected);
    if (actual !== expected)
      report_mismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
  endtask

  task automatic check_aim(input string name, input aim_speed_t actual, input aim_speed_t expected);
    if (actual !== expected)
      report_mismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
  endtask

  // steps falling edges until the write enable reaches the level
  task automatic wait_for_wren(input logic level);
    int cycles;
    cycles = 0;
    while (datatable_wren !== level && cycles < WAIT_LIMIT) begin
      @(negedge clk_74a);
      cycles++;
    end
    if (datatable_wren !== level) begin
      $display("timeout: data-table write enable never went to %0b", level);
      stop_on_error();
    end
  endtask

`endif

/* sim/tb_core_top.sv */
// Testbench for core_top. Inputs change and outputs are sampled on falling edges.
// The data-table RAM model answers one cycle after the address; only words 0-15 exist.

`timescale 1ns/1ps

module tb_core_top;

  import core_pkg::*;

  localparam int           WAIT_LIMIT    = 32;
  localparam int           KEY_ROWS      = 10;
  localparam bridge_data_t ROM_SIZE_WORD = 32'h0008_0000;

  // bridge writes, one per cycle
  localparam bridge_addr_t SET_ADDR [8] = '{32'h100, 32'h104, 32'h108, 32'h10c,
                                           32'h104, 32'h100, 32'h108, 32'h000};
  localparam bridge_data_t SET_DATA [8] = '{32'h1, 32'h3, 32'h5a, 32'hffff_ffff,
                                           32'hffff_fffe, 32'hffff_fffe, 32'h1ff, 32'hffff_ffff};

  // requestread, requestwrite, allcomplete | ioctl_download, save_download
  localparam logic [4:0] FLAG_ROWS [18] = '{
    5'b010_11, 5'b000_11, 5'b001_00, 5'b101_01, 5'b001_01, 5'b001_01,
    5'b011_11, 5'b001_01, 5'b000_01, 5'b001_00, 5'b000_00, 5'b010_11,
    5'b110_11, 5'b000_11, 5'b011_11, 5'b000_11, 5'b001_00, 5'b000_00};

  // sram size code and the save size it stands for
  localparam sram_size_t   SRAM_CODES [5] = '{4'd0, 4'd1, 4'd7, 4'd4, 4'd15};
  localparam bridge_data_t SAVE_SIZES [5] = '{32'd0, 32'd2048, 32'd131072,
                                             32'd16384, 32'd33554432};

  // hblank, vblank, hsync, vsync | de, hs pulse, vs pulse
  localparam logic [6:0] VIDEO_ROWS [14] = '{
    7'b0000_100, 7'b0000_100, 7'b1010_010, 7'b1010_000, 7'b1000_000,
    7'b0000_100, 7'b0101_001, 7'b0111_010, 7'b1111_000, 7'b0100_000,
    7'b0001_101, 7'b0010_110, 7'b0000_100, 7'b0011_111};

  logic            clk_74a;
  logic            pll_core_locked;
  bridge_addr_t    bridge_addr;
  logic            bridge_wr;
  bridge_data_t    bridge_wr_data;
  logic            dataslot_requestread, dataslot_requestwrite, dataslot_allcomplete;
  datatable_addr_t datatable_addr;
  logic            datatable_wren;
  bridge_data_t    datatable_data;
  bridge_data_t    datatable_q;
  sram_size_t      sram_size;
  logic            core_hblank, core_vblank, core_hsync, core_vsync;
  rgb_t            core_rgb;
  key_word_t       cont1_key, cont2_key, cont3_key, cont4_key;
  logic            multitap_enabled, lightgun_enabled, lightgun_type;
  aim_speed_t      lightgun_dpad_aim_speed;
  logic            ioctl_download, save_download;
  bridge_data_t    rom_file_size;
  key_word_t       cont1_key_s, cont2_key_s, cont3_key_s, cont4_key_s;
  rgb_t            video_rgb;
  logic            video_de, video_hs, video_vs;

  bridge_data_t    table_mem [16];
  key_word_t       key_rows [KEY_ROWS][4];

  core_top dut (.*);

  task automatic stop_on_error();
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  `include "tb_checks.svh"

  initial begin
    clk_74a = 1'b0;
    forever #20 clk_74a = ~clk_74a;
  end

  //////////////////////////////////////////////////////////////////////
  // data-table RAM, read address taken on the falling edge

  initial begin
    for (int i = 0; i < 16; i++) begin
      table_mem[i] = 32'hd7a0_0000 + i;
    end
    table_mem[DATATABLE_ROM_SIZE_ADDR[3:0]] = ROM_SIZE_WORD;
    datatable_q = '0;
  end

  always @(negedge clk_74a) begin
    if (datatable_wren)
      table_mem[datatable_addr[3:0]] = datatable_data;
    datatable_q = table_mem[datatable_addr[3:0]];
  end

  task automatic check_reset_values();
    check_bit("multitap_enabled", multitap_enabled, 1'b0);
    check_bit("lightgun_enabled", lightgun_enabled, 1'b0);
    check_bit("lightgun_type", lightgun_type, 1'b0);
    check_aim("lightgun_dpad_aim_speed", lightgun_dpad_aim_speed, '0);
    check_bit("ioctl_download", ioctl_download, 1'b0);
    check_bit("save_download", save_download, 1'b0);
    check_bit("datatable_wren", datatable_wren, 1'b0);
    check_addr("datatable_addr", datatable_addr, '0);
    check_data("datatable_data", datatable_data, '0);
    check_data("rom_file_size", rom_file_size, '0);
    check_key("cont1_key_s", cont1_key_s, '0);
    check_key("cont2_key_s", cont2_key_s, '0);
    check_key("cont3_key_s", cont3_key_s, '0);
    check_key("cont4_key_s", cont4_key_s, '0);
    check_rgb("video_rgb", video_rgb, '0);
    check_bit("video_de", video_de, 1'b0);
    check_bit("video_hs", video_hs, 1'b0);
    check_bit("video_vs", video_vs, 1'b0);
  endtask

  initial begin
    logic        exp_mt;
    logic        exp_lg_en;
    logic        exp_lg_type;
    aim_speed_t  exp_aim;
    logic [31:0] rnd;
    rgb_t        pixel;

    void'($urandom(32'h4346));
    pll_core_locked       = 1'b0;
    bridge_addr           = '0;
    bridge_wr             = 1'b0;
    bridge_wr_data        = '0;
    dataslot_requestread  = 1'b0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
    sram_size             = '0;
    core_hblank           = 1'b0;
    core_vblank           = 1'b0;
    core_hsync            = 1'b0;
    core_vsync            = 1'b0;
    core_rgb              = '0;
    cont1_key             = '0;
    cont2_key             = '0;
    cont3_key             = '0;
    cont4_key             = '0;
    for (int i = 0; i < KEY_ROWS; i++) begin
      for (int c = 0; c < 4; c++) begin
        rnd = $urandom();
        key_rows[i][c] = rnd[15:0];
      end
    end

    // 8 cycles of reset, outputs checked halfway
    repeat (4) @(negedge clk_74a);
    check_reset_values();
    repeat (4) @(negedge clk_74a);
    pll_core_locked = 1'b1;

    // settings bank against a running model
    exp_mt      = 1'b0;
    exp_lg_en   = 1'b0;
    exp_lg_type = 1'b0;
    exp_aim     = '0;
    for (int i = 0; i < 8; i++) begin
      bridge_addr    = SET_ADDR[i];
      bridge_wr_data = SET_DATA[i];
      bridge_wr      = 1'b1;
      @(negedge clk_74a);
      bridge_wr = 1'b0;
      case (SET_ADDR[i])
        SETTINGS_MULTITAP_ADDR: exp_mt = SET_DATA[i][0];
        SETTINGS_LIGHTGUN_ADDR: begin
          exp_lg_en   = SET_DATA[i][0];
          exp_lg_type = SET_DATA[i][1];
        end
        SETTINGS_AIM_SPEED_ADDR: exp_aim = SET_DATA[i][7:0];
        default: ;
      endcase
      check_bit("multitap_enabled", multitap_enabled, exp_mt);
      check_bit("lightgun_enabled", lightgun_enabled, exp_lg_en);
      check_bit("lightgun_type", lightgun_type, exp_lg_type);
      check_aim("lightgun_dpad_aim_speed", lightgun_dpad_aim_speed, exp_aim);
    end

    // download flags, one row per cycle
    for (int i = 0; i < 18; i++) begin
      dataslot_requestread  = FLAG_ROWS[i][4];
      dataslot_requestwrite = FLAG_ROWS[i][3];
      dataslot_allcomplete  = FLAG_ROWS[i][2];
      @(negedge clk_74a);
      check_bit("ioctl_download", ioctl_download, FLAG_ROWS[i][1]);
      check_bit("save_download", save_download, FLAG_ROWS[i][0]);
    end

    //////////////////////////////////////////////////////////////////////
    // data table, a whole write burst after each code change

    for (int i = 0; i < 5; i++) begin
      sram_size = SRAM_CODES[i];
      wait_for_wren(1'b0);
      check_addr("datatable_addr", datatable_addr, DATATABLE_ROM_SIZE_ADDR);
      wait_for_wren(1'b1);
      check_addr("datatable_addr", datatable_addr, DATATABLE_SAVE_SIZE_ADDR);
      check_data("datatable_data", datatable_data, SAVE_SIZES[i]);
      @(negedge clk_74a);
      check_data("table save size word", table_mem[DATATABLE_SAVE_SIZE_ADDR[3:0]],
                 SAVE_SIZES[i]);
      check_data("rom_file_size", rom_file_size, ROM_SIZE_WORD);
    end

    // keys come out SYNC_STAGES cycles after they go in
    for (int i = 0; i < KEY_ROWS + SYNC_STAGES; i++) begin
      if (i >= SYNC_STAGES) begin
        check_key("cont1_key_s", cont1_key_s, key_rows[i-SYNC_STAGES][0]);
        check_key("cont2_key_s", cont2_key_s, key_rows[i-SYNC_STAGES][1]);
        check_key("cont3_key_s", cont3_key_s, key_rows[i-SYNC_STAGES][2]);
        check_key("cont4_key_s", cont4_key_s, key_rows[i-SYNC_STAGES][3]);
      end
      if (i < KEY_ROWS) begin
        cont1_key = key_rows[i][0];
        cont2_key = key_rows[i][1];
        cont3_key = key_rows[i][2];
        cont4_key = key_rows[i][3];
      end
      @(negedge clk_74a);
    end

    // video, held sync rows must not pulse again
    for (int i = 0; i < 14; i++) begin
      rnd         = $urandom();
      pixel       = rnd[23:0];
      core_hblank = VIDEO_ROWS[i][6];
      core_vblank = VIDEO_ROWS[i][5];
      core_hsync  = VIDEO_ROWS[i][4];
      core_vsync  = VIDEO_ROWS[i][3];
      core_rgb    = pixel;
      @(negedge clk_74a);
      check_bit("video_de", video_de, VIDEO_ROWS[i][2]);
      check_rgb("video_rgb", video_rgb, VIDEO_ROWS[i][2] ? pixel : '0);
      check_bit("video_hs", video_hs, VIDEO_ROWS[i][1]);
      check_bit("video_vs", video_vs, VIDEO_ROWS[i][0]);
    end

    repeat (2) @(negedge clk_74a);
    $display("sim passed");
    $finish;
  end

endmodule

/* hw/core_top.sv */
// Glue logic of the game core wrapper, all in the clk_74a domain.
// pll_core_locked low resets every block; the data table is an external RAM
// with one cycle of read latency.

`timescale 1ns/1ps

module core_top (
  input  logic                      clk_74a,
  input  logic                      pll_core_locked,

  // host bridge, one-cycle write strobe
  input  core_pkg::bridge_addr_t    bridge_addr,
  input  logic                      bridge_wr,
  input  core_pkg::bridge_data_t    bridge_wr_data,

  // data slot strobes from the host
  input  logic                      dataslot_requestread,
  input  logic                      dataslot_requestwrite,
  input  logic                      dataslot_allcomplete,

  // data table port
  output core_pkg::datatable_addr_t datatable_addr,
  output logic                      datatable_wren,
  output core_pkg::bridge_data_t    datatable_data,
  input  core_pkg::bridge_data_t    datatable_q,

  // from the core
  input  core_pkg::sram_size_t      sram_size,
  input  logic                      core_hblank,
  input  logic                      core_vblank,
  input  logic                      core_hsync,
  input  logic                      core_vsync,
  input  core_pkg::rgb_t            core_rgb,

  // controller keys
  input  core_pkg::key_word_t       cont1_key,
  input  core_pkg::key_word_t       cont2_key,
  input  core_pkg::key_word_t       cont3_key,
  input  core_pkg::key_word_t       cont4_key,

  // to the core
  output logic                      multitap_enabled,
  output logic                      lightgun_enabled,
  output logic                      lightgun_type,
  output core_pkg::aim_speed_t      lightgun_dpad_aim_speed,
  output logic                      ioctl_download,
  output logic                      save_download,
  output core_pkg::bridge_data_t    rom_file_size,
  output core_pkg::key_word_t       cont1_key_s,
  output core_pkg::key_word_t       cont2_key_s,
  output core_pkg::key_word_t       cont3_key_s,
  output core_pkg::key_word_t       cont4_key_s,

  // video to the scaler
  output core_pkg::rgb_t            video_rgb,
  output logic                      video_de,
  output logic                      video_hs,
  output logic                      video_vs
);

  //////////////////////////////////////////////////////////////////////
  // host side

  bridge_settings u_settings (
    .clk_74a                 (clk_74a),
    .pll_core_locked         (pll_core_locked),
    .bridge_addr             (bridge_addr),
    .bridge_wr               (bridge_wr),
    .bridge_wr_data          (bridge_wr_data),
    .multitap_enabled        (multitap_enabled),
    .lightgun_enabled        (lightgun_enabled),
    .lightgun_type           (lightgun_type),
    .lightgun_dpad_aim_speed (lightgun_dpad_aim_speed)
  );

  dataslot_tracker u_tracker (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .dataslot_requestread  (dataslot_requestread),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .ioctl_download        (ioctl_download),
    .save_download         (save_download)
  );

  datatable_sequencer u_datatable (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .sram_size       (sram_size),
    .datatable_q     (datatable_q),
    .datatable_addr  (datatable_addr),
    .datatable_wren  (datatable_wren),
    .datatable_data  (datatable_data),
    .rom_file_size   (rom_file_size)
  );

  //////////////////////////////////////////////////////////////////////
  // core side

  key_sync u_keys (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .cont1_key       (cont1_key),
    .cont2_key       (cont2_key),
    .cont3_key       (cont3_key),
    .cont4_key       (cont4_key),
    .cont1_key_s     (cont1_key_s),
    .cont2_key_s     (cont2_key_s),
    .cont3_key_s     (cont3_key_s),
    .cont4_key_s     (cont4_key_s)
  );

  video_conditioner u_video (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .core_hblank     (core_hblank),
    .core_vblank     (core_vblank),
    .core_hsync      (core_hsync),
    .core_vsync      (core_vsync),
    .core_rgb        (core_rgb),
    .video_rgb       (video_rgb),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs)
  );

endmodule

/* hw/video_conditioner.sv */
// Registers the core pixel stream for the scaler with one clock of latency.
// RGB is forced to black outside the active area; hs and vs become
// single-cycle pulses on the rising edge of the core sync levels.

`timescale 1ns/1ps

module video_conditioner (
  input  logic           clk_74a,
  input  logic           pll_core_locked,

  input  logic           core_hblank,
  input  logic           core_vblank,
  input  logic           core_hsync,
  input  logic           core_vsync,
  input  core_pkg::rgb_t core_rgb,

  output core_pkg::rgb_t video_rgb,
  output logic           video_de,
  output logic           video_hs,
  output logic           video_vs
);

  logic active;
  logic hs_prev;
  logic vs_prev;

  assign active = !(core_hblank || core_vblank);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      video_de <= active;

      // black during blanking
      if (active) begin
        video_rgb <= core_rgb;
      end else begin
        video_rgb <= '0;
      end

      // rising edge only
      video_hs <= core_hsync && !hs_prev;
      video_vs <= core_vsync && !vs_prev;
      hs_prev  <= core_hsync;
      vs_prev  <= core_vsync;
    end
  end

endmodule

/* hw/key_sync.sv */
// Flop chain for the four controller key bitmaps.
// Latency is SYNC_STAGES clocks; bits are synchronized individually, so a
// multi-bit change may land across two cycles if the source is asynchronous.

`timescale 1ns/1ps

module key_sync (
  input  logic                clk_74a,
  input  logic                pll_core_locked,

  input  core_pkg::key_word_t cont1_key,
  input  core_pkg::key_word_t cont2_key,
  input  core_pkg::key_word_t cont3_key,
  input  core_pkg::key_word_t cont4_key,

  output core_pkg::key_word_t cont1_key_s,
  output core_pkg::key_word_t cont2_key_s,
  output core_pkg::key_word_t cont3_key_s,
  output core_pkg::key_word_t cont4_key_s
);

  import core_pkg::*;

  key_word_t key_in   [4];
  key_word_t key_pipe [4][SYNC_STAGES];

  assign key_in[0] = cont1_key;
  assign key_in[1] = cont2_key;
  assign key_in[2] = cont3_key;
  assign key_in[3] = cont4_key;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      for (int c = 0; c < 4; c++) begin
        for (int s = 0; s < SYNC_STAGES; s++) begin
          key_pipe[c][s] <= '0;
        end
      end
    end else begin
      for (int c = 0; c < 4; c++) begin
        key_pipe[c][0] <= key_in[c];
        for (int s = 1; s < SYNC_STAGES; s++) begin
          key_pipe[c][s] <= key_pipe[c][s-1];
        end
      end
    end
  end

  // last stage out
  assign cont1_key_s = key_pipe[0][SYNC_STAGES-1];
  assign cont2_key_s = key_pipe[1][SYNC_STAGES-1];
  assign cont3_key_s = key_pipe[2][SYNC_STAGES-1];
  assign cont4_key_s = key_pipe[3][SYNC_STAGES-1];

endmodule

/* hw/datatable_sequencer.sv */
// Shares the single data-table port between a ROM size read and a save size write.
// Phases 0-4 read slot 0 size, phases 5-7 write slot 1 size; the cycle is 8 clocks.
// The table RAM must return datatable_q one cycle after the address.

`timescale 1ns/1ps

module datatable_sequencer (
  input  logic                      clk_74a,
  input  logic                      pll_core_locked,

  input  core_pkg::sram_size_t      sram_size,
  input  core_pkg::bridge_data_t    datatable_q,

  output core_pkg::datatable_addr_t datatable_addr,
  output logic                      datatable_wren,
  output core_pkg::bridge_data_t    datatable_data,
  output core_pkg::bridge_data_t    rom_file_size
);

  import core_pkg::*;

  logic [2:0]   phase;
  logic         write_phase;
  bridge_data_t save_size;

  // phases 5..7 own the port for writing
  assign write_phase = (phase > 3'd4);

  // size code to bytes, code 0 means no save ram
  assign save_size = (sram_size == '0) ? '0 : (SAVE_SIZE_UNIT << sram_size);

  //////////////////////////////////////////////////////////////////////
  // port sequencing

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      phase          <= 3'd0;
      datatable_addr <= '0;
      datatable_wren <= 1'b0;
      datatable_data <= '0;
      rom_file_size  <= '0;
    end else begin
      phase <= phase + 3'd1;

      if (write_phase) begin
        datatable_wren <= 1'b1;
        datatable_addr <= DATATABLE_SAVE_SIZE_ADDR;
        datatable_data <= save_size;
      end else begin
        datatable_wren <= 1'b0;
        datatable_addr <= DATATABLE_ROM_SIZE_ADDR;
      end

      // read address has been stable for several cycles by phase 4
      if (phase == 3'd4) begin
        rom_file_size <= datatable_q;
      end
    end
  end

endmodule

/* hw/dataslot_tracker.sv */
// Download flags derived from the host data-slot strobes.
// requestread and requestwrite are one-cycle strobes; allcomplete is a level.
// Everything is in the clk_74a domain, so no crossing is done here.

`timescale 1ns/1ps

module dataslot_tracker (
  input  logic clk_74a,
  input  logic pll_core_locked,

  input  logic dataslot_requestread,
  input  logic dataslot_requestwrite,
  input  logic dataslot_allcomplete,

  output logic ioctl_download,
  output logic save_download
);

  logic allcomplete_prev;
  logic allcomplete_rise;

  assign allcomplete_rise = dataslot_allcomplete && !allcomplete_prev;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      allcomplete_prev <= 1'b0;
      ioctl_download   <= 1'b0;
      save_download    <= 1'b0;
    end else begin
      allcomplete_prev <= dataslot_allcomplete;

      // rom download, request wins over completion
      if (dataslot_requestwrite) begin
        ioctl_download <= 1'b1;
      end else if (dataslot_allcomplete) begin
        ioctl_download <= 1'b0;
      end

      // save flag clears once per completion edge
      if (dataslot_requestread || dataslot_requestwrite) begin
        save_download <= 1'b1;
      end else if (allcomplete_rise) begin
        save_download <= 1'b0;
      end
    end
  end

endmodule

/* hw/bridge_settings.sv */
// Core option registers written by the host bridge.
// Only single-cycle bridge writes to the three settings addresses are decoded;
// the registers cannot be read back over the bridge.

`timescale 1ns/1ps

module bridge_settings (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,

  input  core_pkg::bridge_addr_t bridge_addr,
  input  logic                   bridge_wr,
  input  core_pkg::bridge_data_t bridge_wr_data,

  output logic                   multitap_enabled,
  output logic                   lightgun_enabled,
  output logic                   lightgun_type,
  output core_pkg::aim_speed_t   lightgun_dpad_aim_speed
);

  import core_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // write decode

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      multitap_enabled        <= 1'b0;
      lightgun_enabled        <= 1'b0;
      lightgun_type           <= 1'b0;
      lightgun_dpad_aim_speed <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        SETTINGS_MULTITAP_ADDR: begin
          multitap_enabled <= bridge_wr_data[0];
        end
        SETTINGS_LIGHTGUN_ADDR: begin
          // enable and type share one word
          lightgun_enabled <= bridge_wr_data[0];
          lightgun_type    <= bridge_wr_data[1];
        end
        SETTINGS_AIM_SPEED_ADDR: begin
          lightgun_dpad_aim_speed <= bridge_wr_data[7:0];
        end
        default: begin
          // other bridge traffic is ignored here
        end
      endcase
    end
  end

endmodule

/* hw/core_pkg.sv */
// Shared widths, bridge addresses and data-table constants for the core glue.
// Bridge addresses are byte addresses and are decoded by full compare.
// Data-table addresses are word addresses into the host data table.

package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // vector types

  // bridge byte address
  typedef logic [31:0] bridge_addr_t;

  // bridge write data and data-table words
  typedef logic [31:0] bridge_data_t;

  // one controller key bitmap
  typedef logic [15:0] key_word_t;

  // red [23:16], green [15:8], blue [7:0]
  typedef logic [23:0] rgb_t;

  // data-table word address
  typedef logic [9:0] datatable_addr_t;

  // sram size code reported by the core
  typedef logic [3:0] sram_size_t;

  // lightgun d-pad aim speed
  typedef logic [7:0] aim_speed_t;

  //////////////////////////////////////////////////////////////////////
  // settings register addresses

  // bit 0 is multitap enable
  localparam bridge_addr_t SETTINGS_MULTITAP_ADDR = 32'h0000_0100;

  // bit 0 lightgun enable, bit 1 lightgun type
  localparam bridge_addr_t SETTINGS_LIGHTGUN_ADDR = 32'h0000_0104;

  // bits 7:0 aim speed
  localparam bridge_addr_t SETTINGS_AIM_SPEED_ADDR = 32'h0000_0108;

  //////////////////////////////////////////////////////////////////////
  // data table

  // size entry of data slot 0
  localparam datatable_addr_t DATATABLE_ROM_SIZE_ADDR = 10'd1;

  // size entry of data slot 1, i.e. slot index * 2 + 1
  localparam datatable_addr_t DATATABLE_SAVE_SIZE_ADDR = 10'd3;

  // save size base unit, shifted left by the sram size code
  localparam bridge_data_t SAVE_SIZE_UNIT = 32'd1024;

  // synchronizer depth for controller keys
  localparam int SYNC_STAGES = 3;

endpackage
